// ==== common/vactv_config.svh ====
`ifndef VACTV_CONFIG_SVH
`define VACTV_CONFIG_SVH

// Request tag width, four ids in flight
`define VACTV_ID_WIDTH 2

// Vector shape of one request
`define VACTV_LANES 4
`define VACTV_SUM_WIDTH 8

// Byte address on the memory bus
`define VACTV_ADDR_WIDTH 32

// Derived sizes
`define VACTV_DATA_WIDTH (`VACTV_LANES * `VACTV_SUM_WIDTH)
`define VACTV_NUM_IDS (1 << `VACTV_ID_WIDTH)
`define VACTV_SHIFT_WIDTH 3
`define VACTV_LANES_WIDTH 3

`endif

// ==== common/vactv_pkg.sv ====
`include "vactv_config.svh"

package vactv_pkg;

    // Request tag, also used as the OBI transaction id
    typedef logic [`VACTV_ID_WIDTH-1:0] id_t;

    // One bit per id, for flag vectors and arbiter masks
    typedef logic [`VACTV_NUM_IDS-1:0] mask_t;

    // Byte address of the destination word
    typedef logic [`VACTV_ADDR_WIDTH-1:0] addr_t;

    // One enable per lane byte
    typedef logic [`VACTV_LANES-1:0] be_t;

    // Word written to memory
    typedef logic [`VACTV_DATA_WIDTH-1:0] data_t;

    // Left shift applied after the ReLU
    typedef logic [`VACTV_SHIFT_WIDTH-1:0] shift_t;

    // Active lane count, 0 up to the full lane count
    typedef logic [`VACTV_LANES_WIDTH-1:0] lanes_t;

    // A single signed partial sum
    typedef logic signed [`VACTV_SUM_WIDTH-1:0] sum_t;

    // Partial sums as they arrive (flat) and as the datapath reads them (per lane).
    // Lane 0 sits in the least significant byte
    typedef union packed {
        data_t                   flat;
        sum_t [`VACTV_LANES-1:0] lane;
    } sums_u;

endpackage

// ==== src/rr_arbiter.sv ====
`include "vactv_config.svh"

module rr_arbiter (
    input  logic             clk,
    input  logic             rstn,
    input  vactv_pkg::mask_t mask,
    input  logic             advance,
    output vactv_pkg::id_t   sel_id,
    output logic             sel_valid
);

    // Priority pointer, highest priority id
    vactv_pkg::id_t ptr_q;

    // Scan from the farthest offset down so the nearest set bit wins
    always_comb begin : pick
        vactv_pkg::id_t cand;

        sel_id    = ptr_q;
        sel_valid = 1'b0;
        for (int i = `VACTV_NUM_IDS - 1; i >= 0; i--) begin
            // Wraps naturally at the id width
            cand = ptr_q + vactv_pkg::id_t'(i);
            if (mask[cand]) begin
                sel_id    = cand;
                sel_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ptr_q <= '0;
        end else if (advance && sel_valid) begin
            ptr_q <= sel_id + 1'b1;
        end
    end

endmodule

// ==== vactv/vactv_activate.sv ====
`include "vactv_config.svh"

module vactv_activate (
    input  vactv_pkg::shift_t shift,
    input  vactv_pkg::lanes_t lanes,
    input  vactv_pkg::sums_u  sums,
    output vactv_pkg::data_t  wdata,
    output vactv_pkg::be_t    be
);

    // ReLU, then shift left; the result keeps only the low byte of each lane
    always_comb begin : relu_shift
        vactv_pkg::sum_t lane_in;
        logic [`VACTV_SUM_WIDTH-1:0] lane_out;

        wdata = '0;
        be    = '0;
        for (int i = 0; i < `VACTV_LANES; i++) begin
            lane_in  = sums.lane[i];
            lane_out = '0;
            if (i < int'(lanes)) begin
                be[i] = 1'b1;
                // Zero and negative sums clamp to 0
                if (lane_in > 0) begin
                    lane_out = lane_in << shift;
                end
            end
            wdata[i*`VACTV_SUM_WIDTH +: `VACTV_SUM_WIDTH] = lane_out;
        end
    end

endmodule

// ==== vactv/vactv_scoreboard.sv ====
`include "vactv_config.svh"

module vactv_scoreboard (
    input  logic               clk,
    input  logic               rstn,
    input  logic               req_valid,
    input  vactv_pkg::id_t     req_id,
    input  vactv_pkg::addr_t   req_addr,
    input  vactv_pkg::shift_t  req_shift,
    input  vactv_pkg::lanes_t  req_lanes,
    input  vactv_pkg::data_t   req_sums,
    input  vactv_pkg::id_t     issue_id,
    input  logic               grant,
    input  vactv_pkg::id_t     grant_id,
    input  logic               ack,
    input  vactv_pkg::id_t     ack_id,
    input  logic               resp_ready,
    input  vactv_pkg::id_t     done_sel_id,
    input  logic               done_sel_valid,
    output logic               req_ready,
    output logic               resp_valid,
    output vactv_pkg::id_t     resp_id,
    output vactv_pkg::mask_t   issue_mask,
    output vactv_pkg::mask_t   done_mask,
    output vactv_pkg::addr_t   entry_addr,
    output vactv_pkg::shift_t  entry_shift,
    output vactv_pkg::lanes_t  entry_lanes,
    output vactv_pkg::sums_u   entry_sums
);

    // Per-id flags
    vactv_pkg::mask_t accepted_q;
    vactv_pkg::mask_t granted_q;
    vactv_pkg::mask_t acked_q;

    // Per-id request payload
    vactv_pkg::addr_t  addr_q  [`VACTV_NUM_IDS];
    vactv_pkg::shift_t shift_q [`VACTV_NUM_IDS];
    vactv_pkg::lanes_t lanes_q [`VACTV_NUM_IDS];
    vactv_pkg::sums_u  sums_q  [`VACTV_NUM_IDS];

    logic accept;
    logic resp_load;

    // An id stays busy from acceptance until its response handshake
    assign req_ready = !accepted_q[req_id];
    assign accept    = req_valid && req_ready;

    // Acked flag is dropped once the response register takes the id
    assign issue_mask = accepted_q & ~granted_q;
    assign done_mask  = acked_q;

    // Response register refills on the handshake cycle too
    assign resp_load = done_sel_valid && (!resp_valid || resp_ready);

    assign entry_addr  = addr_q[issue_id];
    assign entry_shift = shift_q[issue_id];
    assign entry_lanes = lanes_q[issue_id];
    assign entry_sums  = sums_q[issue_id];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            accepted_q <= '0;
            granted_q  <= '0;
            acked_q    <= '0;
            resp_valid <= 1'b0;
            resp_id    <= '0;
        end else begin
            if (resp_valid && resp_ready) begin
                accepted_q[resp_id] <= 1'b0;
                granted_q[resp_id]  <= 1'b0;
                resp_valid          <= 1'b0;
            end
            if (accept) begin
                accepted_q[req_id] <= 1'b1;
            end
            if (grant) begin
                granted_q[grant_id] <= 1'b1;
            end
            if (ack) begin
                acked_q[ack_id] <= 1'b1;
            end
            if (resp_load) begin
                acked_q[done_sel_id] <= 1'b0;
                resp_valid           <= 1'b1;
                resp_id              <= done_sel_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q[req_id]       <= req_addr;
            shift_q[req_id]      <= req_shift;
            lanes_q[req_id]      <= req_lanes;
            sums_q[req_id].flat  <= req_sums;
        end
    end

    // A free id must carry no leftover grant or acknowledge
    a_accept_clean: assert property (@(posedge clk) disable iff (!rstn)
        accept |-> !granted_q[req_id] && !acked_q[req_id]);

    // Controller only grants issued entries, and only once
    a_grant_owned: assert property (@(posedge clk) disable iff (!rstn)
        grant |-> accepted_q[grant_id] && !granted_q[grant_id]);

    // Memory only acknowledges granted writes
    a_ack_owned: assert property (@(posedge clk) disable iff (!rstn)
        ack |-> accepted_q[ack_id] && granted_q[ack_id] && !acked_q[ack_id]);

endmodule

// ==== vactv/vactv_obi_ctrl.sv ====
module vactv_obi_ctrl (
    input  logic              clk,
    input  logic              rstn,
    input  logic              issue_valid,
    input  vactv_pkg::id_t    issue_id,
    input  vactv_pkg::addr_t  addr,
    input  vactv_pkg::data_t  wdata,
    input  vactv_pkg::be_t    be,
    input  logic              obi_gnt,
    input  logic              obi_rvalid,
    input  vactv_pkg::id_t    obi_rid,
    output logic              obi_req,
    output vactv_pkg::addr_t  obi_addr,
    output vactv_pkg::be_t    obi_be,
    output vactv_pkg::data_t  obi_wdata,
    output vactv_pkg::id_t    obi_aid,
    output logic              grant,
    output vactv_pkg::id_t    grant_id,
    output logic              ack,
    output vactv_pkg::id_t    ack_id
);

    typedef enum logic {
        IDLE,
        REQ
    } state_t;

    state_t state;
    logic   load;

    assign load    = (state == IDLE) && issue_valid;
    assign obi_req = (state == REQ);

    // Grant is reported in the handshake cycle so the issue mask drops the id
    // before the controller is idle again
    assign grant    = obi_req && obi_gnt;
    assign grant_id = obi_aid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            ack <= obi_rvalid;
            case (state)
                IDLE: begin
                    if (issue_valid) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (obi_gnt) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Bus fields are captured once per request and held until grant
    always_ff @(posedge clk) begin
        if (load) begin
            obi_addr  <= addr;
            obi_be    <= be;
            obi_wdata <= wdata;
            obi_aid   <= issue_id;
        end
        if (obi_rvalid) begin
            ack_id <= obi_rid;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        obi_req && !obi_gnt |=> obi_req && $stable(obi_addr) && $stable(obi_be)
            && $stable(obi_wdata) && $stable(obi_aid));

endmodule

// ==== src/vactv_top.sv ====
module vactv_top (
    input  logic              clk,
    input  logic              rstn,
    input  logic              req_valid,
    output logic              req_ready,
    input  vactv_pkg::id_t    req_id,
    input  vactv_pkg::addr_t  req_addr,
    input  vactv_pkg::shift_t req_shift,
    input  vactv_pkg::lanes_t req_lanes,
    input  vactv_pkg::data_t  req_sums,
    output logic              resp_valid,
    input  logic              resp_ready,
    output vactv_pkg::id_t    resp_id,
    output logic              obi_req,
    input  logic              obi_gnt,
    output vactv_pkg::addr_t  obi_addr,
    output vactv_pkg::be_t    obi_be,
    output vactv_pkg::data_t  obi_wdata,
    output vactv_pkg::id_t    obi_aid,
    input  logic              obi_rvalid,
    input  vactv_pkg::id_t    obi_rid
);

    vactv_pkg::mask_t  issue_mask;
    vactv_pkg::mask_t  done_mask;
    vactv_pkg::id_t    issue_id;
    logic              issue_valid;
    vactv_pkg::id_t    done_sel_id;
    logic              done_sel_valid;
    logic              resp_advance;
    vactv_pkg::addr_t  entry_addr;
    vactv_pkg::shift_t entry_shift;
    vactv_pkg::lanes_t entry_lanes;
    vactv_pkg::sums_u  entry_sums;
    vactv_pkg::data_t  act_wdata;
    vactv_pkg::be_t    act_be;
    logic              grant;
    vactv_pkg::id_t    grant_id;
    logic              ack;
    vactv_pkg::id_t    ack_id;

    // Same condition under which the scoreboard loads its response register
    assign resp_advance = done_sel_valid && (!resp_valid || resp_ready);

    vactv_scoreboard i_scoreboard (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req_id         (req_id),
        .req_addr       (req_addr),
        .req_shift      (req_shift),
        .req_lanes      (req_lanes),
        .req_sums       (req_sums),
        .issue_id       (issue_id),
        .grant          (grant),
        .grant_id       (grant_id),
        .ack            (ack),
        .ack_id         (ack_id),
        .resp_ready     (resp_ready),
        .done_sel_id    (done_sel_id),
        .done_sel_valid (done_sel_valid),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_id        (resp_id),
        .issue_mask     (issue_mask),
        .done_mask      (done_mask),
        .entry_addr     (entry_addr),
        .entry_shift    (entry_shift),
        .entry_lanes    (entry_lanes),
        .entry_sums     (entry_sums)
    );

    vactv_activate i_activate (
        .shift (entry_shift),
        .lanes (entry_lanes),
        .sums  (entry_sums),
        .wdata (act_wdata),
        .be    (act_be)
    );

    vactv_obi_ctrl i_obi_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .issue_id    (issue_id),
        .addr        (entry_addr),
        .wdata       (act_wdata),
        .be          (act_be),
        .obi_gnt     (obi_gnt),
        .obi_rvalid  (obi_rvalid),
        .obi_rid     (obi_rid),
        .obi_req     (obi_req),
        .obi_addr    (obi_addr),
        .obi_be      (obi_be),
        .obi_wdata   (obi_wdata),
        .obi_aid     (obi_aid),
        .grant       (grant),
        .grant_id    (grant_id),
        .ack         (ack),
        .ack_id      (ack_id)
    );

    // Picks the next accepted entry to write
    rr_arbiter i_issue_arb (
        .clk       (clk),
        .rstn      (rstn),
        .mask      (issue_mask),
        .advance   (grant),
        .sel_id    (issue_id),
        .sel_valid (issue_valid)
    );

    // Picks the next acknowledged entry to respond
    rr_arbiter i_resp_arb (
        .clk       (clk),
        .rstn      (rstn),
        .mask      (done_mask),
        .advance   (resp_advance),
        .sel_id    (done_sel_id),
        .sel_valid (done_sel_valid)
    );

endmodule

// ==== tb/obi_mem_model.sv ====
`include "vactv_config.svh"

module obi_mem_model #(
    parameter logic [31:0] SEED = 32'h43c31d26
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             obi_req,
    input  vactv_pkg::addr_t obi_addr,
    input  vactv_pkg::be_t   obi_be,
    input  vactv_pkg::data_t obi_wdata,
    input  vactv_pkg::id_t   obi_aid,
    output logic             obi_gnt,
    output logic             obi_rvalid,
    output vactv_pkg::id_t   obi_rid
);
    timeunit 1ns;
    timeprecision 100ps;

    // 256 words, byte addresses 0x000 to 0x3ff
    vactv_pkg::data_t mem [256];

    // Granted writes waiting for their acknowledge, oldest first
    vactv_pkg::id_t   ack_ids [$];
    int               ack_due [$];
    int               cycle;
    int               gnt_wait;
    integer           seed;

    function automatic vactv_pkg::data_t fill_word(input int unsigned addr);
        return (addr * 32'h9e3779b1) ^ 32'ha5c33c5a;
    endfunction

    function automatic int draw_delay();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    initial begin
        seed = SEED;
        for (int w = 0; w < 256; w++) begin
            mem[w] = fill_word(w * 4);
        end
    end

    // Grant once the drawn wait has run out
    assign obi_gnt = obi_req && (gnt_wait == 0);

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cycle      <= 0;
            gnt_wait   <= 0;
            obi_rvalid <= 1'b0;
            obi_rid    <= '0;
            ack_ids.delete();
            ack_due.delete();
        end else begin
            cycle      <= cycle + 1;
            obi_rvalid <= 1'b0;
            if (ack_ids.size() > 0 && cycle >= ack_due[0]) begin
                obi_rvalid <= 1'b1;
                obi_rid    <= ack_ids.pop_front();
                void'(ack_due.pop_front());
            end
            if (obi_gnt) begin
                for (int b = 0; b < `VACTV_LANES; b++) begin
                    if (obi_be[b]) begin
                        mem[obi_addr[9:2]][b*8 +: 8] <= obi_wdata[b*8 +: 8];
                    end
                end
                ack_ids.push_back(obi_aid);
                ack_due.push_back(cycle + 1 + draw_delay());
                gnt_wait <= draw_delay();
            end else if (obi_req) begin
                gnt_wait <= gnt_wait - 1;
            end
        end
    end

endmodule

// ==== tb/tb_vactv.sv ====
`include "vactv_config.svh"

module tb_vactv;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;

    logic              clk;
    logic              rstn;
    logic              req_valid;
    logic              req_ready;
    vactv_pkg::id_t    req_id;
    vactv_pkg::addr_t  req_addr;
    vactv_pkg::shift_t req_shift;
    vactv_pkg::lanes_t req_lanes;
    vactv_pkg::data_t  req_sums;
    logic              resp_valid;
    logic              resp_ready;
    vactv_pkg::id_t    resp_id;
    logic              obi_req;
    logic              obi_gnt;
    vactv_pkg::addr_t  obi_addr;
    vactv_pkg::be_t    obi_be;
    vactv_pkg::data_t  obi_wdata;
    vactv_pkg::id_t    obi_aid;
    logic              obi_rvalid;
    vactv_pkg::id_t    obi_rid;

    // Test vectors with one entry per line of the data file
    vactv_pkg::id_t    t_id    [$];
    vactv_pkg::addr_t  t_addr  [$];
    vactv_pkg::shift_t t_shift [$];
    vactv_pkg::lanes_t t_lanes [$];
    vactv_pkg::data_t  t_sums  [$];
    vactv_pkg::data_t  t_word  [$];
    vactv_pkg::be_t    t_be    [$];
    vactv_pkg::data_t  t_old   [$];
    int                t_errs  [$];

    int     num_tests;
    int     error_count;
    int     done_count;
    int     drv_idx;
    int     stall_cycles;
    int     max_busy;
    logic   loaded;
    integer seed;

    // Expected state of each id
    logic [`VACTV_NUM_IDS-1:0] busy;
    logic [`VACTV_NUM_IDS-1:0] written;
    int                        id_test [`VACTV_NUM_IDS];
    logic                      hold_valid;
    vactv_pkg::id_t            hold_id;

    vactv_top i_vactv_top (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_id     (req_id),
        .req_addr   (req_addr),
        .req_shift  (req_shift),
        .req_lanes  (req_lanes),
        .req_sums   (req_sums),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_id    (resp_id),
        .obi_req    (obi_req),
        .obi_gnt    (obi_gnt),
        .obi_addr   (obi_addr),
        .obi_be     (obi_be),
        .obi_wdata  (obi_wdata),
        .obi_aid    (obi_aid),
        .obi_rvalid (obi_rvalid),
        .obi_rid    (obi_rid)
    );

    obi_mem_model #(.SEED(32'h43c31d26)) i_mem (
        .clk        (clk),
        .rstn       (rstn),
        .obi_req    (obi_req),
        .obi_addr   (obi_addr),
        .obi_be     (obi_be),
        .obi_wdata  (obi_wdata),
        .obi_aid    (obi_aid),
        .obi_gnt    (obi_gnt),
        .obi_rvalid (obi_rvalid),
        .obi_rid    (obi_rid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp, input int test_idx);
        if (got !== exp) begin
            error_count++;
            if (test_idx >= 0) begin
                t_errs[test_idx]++;
            end
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0d ns, %0d of %0d tests done", why, $time, done_count, num_tests);
        $display("** FAIL **");
        $finish;
    endtask

    function automatic vactv_pkg::data_t byte_mask(input vactv_pkg::be_t be);
        vactv_pkg::data_t m;

        m = '0;
        for (int b = 0; b < `VACTV_LANES; b++) begin
            if (be[b]) begin
                m[b*`VACTV_SUM_WIDTH +: `VACTV_SUM_WIDTH] = '1;
            end
        end
        return m;
    endfunction

    // Disabled bytes keep what the memory held before the write
    function automatic vactv_pkg::data_t expected_word(input int k);
        vactv_pkg::data_t m;

        m = byte_mask(t_be[k]);
        return (t_old[k] & ~m) | (t_word[k] & m);
    endfunction

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_id;
        logic [31:0] f_addr;
        logic [31:0] f_shift;
        logic [31:0] f_lanes;
        logic [31:0] f_sums;
        logic [31:0] f_word;
        logic [31:0] f_be;

        fd = $fopen("tb/vactv_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/vactv_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                f_id, f_addr, f_shift, f_lanes, f_sums, f_word, f_be);
                    if (n == 7) begin
                        t_id.push_back(vactv_pkg::id_t'(f_id));
                        t_addr.push_back(f_addr);
                        t_shift.push_back(vactv_pkg::shift_t'(f_shift));
                        t_lanes.push_back(vactv_pkg::lanes_t'(f_lanes));
                        t_sums.push_back(f_sums);
                        t_word.push_back(f_word);
                        t_be.push_back(vactv_pkg::be_t'(f_be));
                        t_old.push_back('0);
                        t_errs.push_back(0);
                    end else if (n > 0) begin
                        error_count++;
                        $display("Malformed line in test file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        num_tests = t_id.size();
    endtask

    task automatic present(input int k);
        req_valid <= 1'b1;
        req_id    <= t_id[k];
        req_addr  <= t_addr[k];
        req_shift <= t_shift[k];
        req_lanes <= t_lanes[k];
        req_sums  <= t_sums[k];
        drv_idx   <= k;
    endtask

    // Idle outputs and every id free after reset
    task automatic check_reset();
        for (int i = 0; i <= `VACTV_NUM_IDS; i++) begin
            @(posedge clk);
            check_value("resp_valid after reset", resp_valid, 0, -1);
            check_value("obi_req after reset", obi_req, 0, -1);
            if (i > 0) begin
                check_value("req_ready after reset", req_ready, 1, -1);
            end
            if (i < `VACTV_NUM_IDS) begin
                req_id <= vactv_pkg::id_t'(i);
            end
        end
    endtask

    // Requests go out back to back and each is held until accepted
    task automatic drive_tests();
        int k;

        k = 0;
        @(posedge clk);
        present(0);
        while (k < num_tests) begin
            @(posedge clk);
            if (req_ready) begin
                k++;
                if (k < num_tests) begin
                    present(k);
                end else begin
                    req_valid <= 1'b0;
                end
            end
        end
    endtask

    // Response back-pressure that is low about a third of the cycles
    always @(posedge clk) begin
        if (!rstn) begin
            resp_ready <= 1'b0;
        end else begin
            resp_ready <= ($unsigned($random(seed)) % 3) != 0;
        end
    end

    always @(posedge clk) begin
        int k;

        if (rstn) begin
            if (hold_valid) begin
                check_value("resp_valid under back-pressure", resp_valid, 1, -1);
                check_value("resp_id under back-pressure", resp_id, hold_id, -1);
            end
            if (req_valid) begin
                check_value("req_ready", req_ready, !busy[req_id], drv_idx);
                if (busy[req_id]) begin
                    stall_cycles++;
                end
                if (req_ready) begin
                    busy[req_id]    = 1'b1;
                    written[req_id] = 1'b0;
                    id_test[req_id] = drv_idx;
                    t_old[drv_idx]  = i_mem.mem[req_addr[9:2]];
                end
            end
            if ($countones(busy) > max_busy) begin
                max_busy = $countones(busy);
            end
            if (obi_req && obi_gnt) begin
                k = id_test[obi_aid];
                check_value("write to a busy id", busy[obi_aid], 1, -1);
                check_value("second write for one request", written[obi_aid], 0, k);
                check_value("obi_addr", obi_addr, t_addr[k], k);
                check_value("obi_be", obi_be, t_be[k], k);
                check_value("obi_wdata", obi_wdata, t_word[k], k);
                written[obi_aid] = 1'b1;
            end
            if (resp_valid && resp_ready) begin
                check_value("response to a busy id", busy[resp_id], 1, -1);
                if (busy[resp_id]) begin
                    k = id_test[resp_id];
                    check_value("write before response", written[resp_id], 1, k);
                    check_value("memory word", i_mem.mem[t_addr[k][9:2]], expected_word(k), k);
                    busy[resp_id] = 1'b0;
                    done_count++;
                    $display("test %0d id %0d addr %h: %s", k, resp_id, t_addr[k],
                             (t_errs[k] == 0) ? "ok" : "mismatch");
                end
            end
            hold_valid = resp_valid && !resp_ready;
            hold_id    = resp_id;
        end
    end

    initial begin
        wait (loaded);
        #(num_tests * 100 * CLK_PERIOD);
        abort_run("Run timed out waiting for responses");
    end

    initial begin
        seed         = 32'h43c31d26;
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_id       = '0;
        req_addr     = '0;
        req_shift    = '0;
        req_lanes    = '0;
        req_sums     = '0;
        resp_ready   = 1'b0;
        error_count  = 0;
        done_count   = 0;
        drv_idx      = 0;
        stall_cycles = 0;
        max_busy     = 0;
        busy         = '0;
        written      = '0;
        hold_valid   = 1'b0;
        hold_id      = '0;
        loaded       = 1'b0;
        load_tests();
        if (num_tests == 0) begin
            abort_run("No tests found in tb/vactv_tests.txt");
        end else begin
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            rstn <= 1'b1;
            check_reset();
            drive_tests();
            wait (done_count == num_tests);
            repeat (4) @(posedge clk);
            check_value("peak ids in flight", max_busy, `VACTV_NUM_IDS, -1);
            check_value("busy id stall seen", stall_cycles > 0, 1, -1);
            $display("tests %0d, responses %0d, errors %0d",
                     num_tests, done_count, error_count);
            if (error_count == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule

// ==== tb/vactv_tests.txt ====
# id addr shift lanes sums expected_word expected_be, all hex
# Lane 0 is the low byte of sums and of the expected word
0 00000000 0 4 017f80ff 017f0000 f
1 00000004 1 4 40002185 80004200 f
2 00000008 3 3 103f2205 00f81028 7
3 0000000c 7 2 7f010302 00008000 3
0 00000010 2 1 11223310 00000040 1
0 00000014 0 0 7f7f7f7f 00000000 0
1 00000018 4 4 0ff00801 f0008010 f
2 0000001c 5 4 00000000 00000000 f
3 00000020 6 3 55028103 008000c0 7
2 00000024 1 2 7f7f7f7f 0000fefe 3
1 00000028 0 4 80808080 00000000 f
3 0000002c 7 4 01010101 80808080 f
3 00000030 2 4 3f20c01f fc80007c f
2 00000034 0 1 ffffff05 00000005 1
1 00000038 3 2 0000ff7e 000000f0 3
0 0000003c 5 3 0109000a 00200040 7
0 00000040 1 0 01020304 00000000 0
1 00000044 4 4 12345678 20406080 f
2 00000048 6 4 7f817f81 c000c000 f
3 0000004c 0 3 7f7f8001 007f0001 7
3 00000050 2 4 40201008 00804020 f
0 00000054 7 1 00000003 00000080 1
1 00000058 3 4 e01f02ff 00f81000 f
2 0000005c 1 2 0000807f 000000fe 3

// ==== compile.f ====
+incdir+common
common/vactv_pkg.sv
src/rr_arbiter.sv
vactv/vactv_activate.sv
vactv/vactv_scoreboard.sv
vactv/vactv_obi_ctrl.sv
src/vactv_top.sv
tb/obi_mem_model.sv
tb/tb_vactv.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_vactv -f compile.f --Mdir obj_dir -o sim_vactv

output=$(./obj_dir/sim_vactv)
echo "$output"

echo "$output" | grep -qxF '** PASS **'
